// File: hdl/cl_fifo_pkg.sv
// Shared widths, defaults and types of the write-to-stream shell wrapper
// Referenced by scoped names from the RTL and the testbench

package cl_fifo_pkg;

  // Stream and host write data
  localparam int DATA_W_DEF = 64;
  localparam int ID_W = 6;

  // Statistics space
  localparam int STAT_ADDR_W = 8;
  localparam int STAT_DATA_W = 32;
  localparam int NUM_STAT_REGS = 4;

  // Register stages on each statistics path
  localparam int STAT_STAGES_DEF = 8;

  // Stream FIFO and credit defaults
  localparam int FIFO_DEPTH_DEF = 16;
  localparam int CREDITS_DEF = 4;

  // AXI write response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Statistics request word
  // The pipeline carries it flat, the endpoints decode the fields
  typedef union packed {
    logic [1 + 1 + STAT_ADDR_W + STAT_DATA_W - 1:0] raw;
    struct packed {
      logic                   wr;
      logic                   rd;
      logic [STAT_ADDR_W-1:0] addr;
      logic [STAT_DATA_W-1:0] wdata;
    } fields;
  } stat_req_u;

  // Statistics acknowledge word
  typedef struct packed {
    logic                   ack;
    logic [STAT_DATA_W-1:0] rdata;
  } stat_ack_t;

endpackage

// File: hdl/axis_if.sv
// Stream link from the write interceptor into the FIFO
// A beat moves on a clock edge with tvalid and tready both high

`timescale 1ns/1ps

interface axis_if #(
  parameter int DATA_W = cl_fifo_pkg::DATA_W_DEF
);

  logic [DATA_W-1:0] tdata;
  logic              tlast;
  logic              tvalid;
  // Low while the FIFO is full
  logic              tready;

  modport src (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport dst (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

// File: hdl/cl_reset_flr.sv
// Internal reset generation and function-level reset handshake
// sync_rst_n follows pipe_rst_n through two flops; flr_done answers flr_assert

`timescale 1ns/1ps

module cl_reset_flr (
  input  logic clk,
  input  logic pipe_rst_n,
  input  logic flr_assert,
  output logic sync_rst_n,
  output logic flr_done
);

  logic pre_sync_rst_n;
  logic flr_q;

  // Two-flop reset chain
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n     <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n     <= pre_sync_rst_n;
    end
  end

  // Done toggles while the request stays high and pulses once for a short request
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      flr_q    <= 1'b0;
      flr_done <= 1'b0;
    end
    else
    begin
      flr_q    <= flr_assert;
      flr_done <= flr_q && !flr_done;
    end
  end

  // A done pulse answers a request sampled two cycles before
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    flr_done |-> $past(flr_assert, 2));

endmodule

// File: hdl/lib_pipe.sv
// Register pipeline of fixed depth with synchronous clear
// Used for timing relief on the statistics request and acknowledge paths

`timescale 1ns/1ps

module lib_pipe #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 1
) (
  input  logic             clk,
  input  logic             sync_rst_n,
  input  logic [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  logic [WIDTH-1:0] stage_q [STAGES];

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= in_bus;
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out_bus = stage_q[STAGES-1];

endmodule

// File: hdl/ddr_stat_regs.sv
// Small statistics register block behind the request pipeline
// Low address bits select a register, anything above is unmapped and reads zero

`timescale 1ns/1ps

module ddr_stat_regs (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  cl_fifo_pkg::stat_req_u req,
  output cl_fifo_pkg::stat_ack_t ack
);

  localparam int IDX_W = $clog2(cl_fifo_pkg::NUM_STAT_REGS);

  logic [cl_fifo_pkg::STAT_DATA_W-1:0] regs [cl_fifo_pkg::NUM_STAT_REGS];
  logic [IDX_W-1:0]                    idx;
  logic                                mapped;

  assign idx    = req.fields.addr[IDX_W-1:0];
  assign mapped = (req.fields.addr >> IDX_W) == '0;

  //////////////////////////////////////////////////
  // Register file and ack, one cycle per request
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < cl_fifo_pkg::NUM_STAT_REGS; i++)
      begin
        regs[i] <= '0;
      end
      ack <= '0;
    end
    else
    begin
      ack.ack   <= req.fields.wr || req.fields.rd;
      // Write acks return zero data
      ack.rdata <= '0;
      if (req.fields.wr && mapped)
      begin
        regs[idx] <= req.fields.wdata;
      end
      if (req.fields.rd && mapped)
      begin
        ack.rdata <= regs[idx];
      end
    end
  end

  // Host side must never issue read and write in the same word
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    req.fields.wr |-> !req.fields.rd);

endmodule

// File: hdl/pcis_wr_intercept.sv
// Catches host DMA write bursts and turns the data beats into a stream
// One burst at a time; the response goes back once its last beat is in the FIFO

`timescale 1ns/1ps

module pcis_wr_intercept #(
  parameter int DATA_W = cl_fifo_pkg::DATA_W_DEF
) (
  input  logic                         clk,
  input  logic                         sync_rst_n,
  // AW channel
  input  logic                         awvalid,
  input  logic [cl_fifo_pkg::ID_W-1:0] awid,
  output logic                         awready,
  // W channel
  input  logic                         wvalid,
  input  logic [DATA_W-1:0]            wdata,
  input  logic                         wlast,
  output logic                         wready,
  // B channel
  output logic                         bvalid,
  output logic [cl_fifo_pkg::ID_W-1:0] bid,
  output logic [1:0]                   bresp,
  input  logic                         bready,
  axis_if.src                          strm
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_DATA = 2'd1;
  localparam logic [1:0] S_RESP = 2'd2;

  logic [1:0]                   state;
  logic [cl_fifo_pkg::ID_W-1:0] id_q;

  //////////////////////////////////////////////////
  // Burst tracker
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      state <= S_IDLE;
    end
    else
    begin
      case (state)
        S_IDLE:  if (awvalid) state <= S_DATA;
        S_DATA:  if (wvalid && wready && wlast) state <= S_RESP;
        S_RESP:  if (bready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ID held for the response
  always_ff @(posedge clk)
  begin
    if (awvalid && awready)
    begin
      id_q <= awid;
    end
  end

  assign awready = (state == S_IDLE);
  // Data only flows inside an open burst
  assign wready  = (state == S_DATA) && strm.tready;

  assign strm.tvalid = wvalid && (state == S_DATA);
  assign strm.tdata  = wdata;
  assign strm.tlast  = wlast;

  assign bvalid = (state == S_RESP);
  assign bid    = id_q;
  assign bresp  = cl_fifo_pkg::RESP_OKAY;

  // A W beat held off by wready stays on the bus unchanged
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wlast)));

endmodule

// File: hdl/axis_fifo.sv
// Stream FIFO with a credit-counted output port
// Each sent beat spends a credit and each out_credit cycle returns one

`timescale 1ns/1ps

module axis_fifo #(
  parameter int DATA_W     = cl_fifo_pkg::DATA_W_DEF,
  parameter int FIFO_DEPTH = cl_fifo_pkg::FIFO_DEPTH_DEF,
  parameter int CREDITS    = cl_fifo_pkg::CREDITS_DEF
) (
  input  logic              clk,
  input  logic              sync_rst_n,
  axis_if.dst               strm,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_credit
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  logic [DATA_W-1:0] mem_data [FIFO_DEPTH];
  logic              mem_last [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRD_W-1:0]  credit_cnt;
  logic              push;
  logic              pop;

  assign strm.tready = (count != CNT_W'(FIFO_DEPTH));
  assign push        = strm.tvalid && strm.tready;
  // Pop only with data present and a credit in hand
  assign pop         = (count != '0) && (credit_cnt != '0);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_data[wr_ptr] <= strm.tdata;
      mem_last[wr_ptr] <= strm.tlast;
    end
  end

  // Pointers, occupancy and credits
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= CRD_W'(CREDITS);
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count      <= count + CNT_W'(push) - CNT_W'(pop);
      credit_cnt <= credit_cnt - CRD_W'(pop) + CRD_W'(out_credit);
    end
  end

  //////////////////////////////////////////////////
  // Registered output stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= pop;
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      out_data <= mem_data[rd_ptr];
      out_last <= mem_last[rd_ptr];
    end
  end

  // Receiver returns no more credits than it was given
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    credit_cnt <= CRD_W'(CREDITS));

  // Occupancy stays within the depth and matches the pointer distance
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    (count <= CNT_W'(FIFO_DEPTH)) &&
    ((int'(count) % FIFO_DEPTH) ==
     ((int'(wr_ptr) - int'(rd_ptr) + FIFO_DEPTH) % FIFO_DEPTH)));

endmodule

// File: hdl/cl_fifo_top.sv
// Shell-side wrapper top: reset/FLR, host write capture to a credited stream
// and the pipelined statistics register path

`timescale 1ns/1ps

module cl_fifo_top #(
  parameter int DATA_W      = cl_fifo_pkg::DATA_W_DEF,
  parameter int FIFO_DEPTH  = cl_fifo_pkg::FIFO_DEPTH_DEF,
  parameter int CREDITS     = cl_fifo_pkg::CREDITS_DEF,
  parameter int STAT_STAGES = cl_fifo_pkg::STAT_STAGES_DEF
) (
  input  logic                                clk,
  input  logic                                pipe_rst_n,
  input  logic                                flr_assert,
  output logic                                flr_done,
  // Host write channels
  input  logic                                awvalid,
  input  logic [cl_fifo_pkg::ID_W-1:0]        awid,
  output logic                                awready,
  input  logic                                wvalid,
  input  logic [DATA_W-1:0]                   wdata,
  input  logic                                wlast,
  output logic                                wready,
  output logic                                bvalid,
  output logic [cl_fifo_pkg::ID_W-1:0]        bid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  // Credited stream out
  output logic                                out_valid,
  output logic [DATA_W-1:0]                   out_data,
  output logic                                out_last,
  input  logic                                out_credit,
  // Statistics port
  input  logic                                stat_wr,
  input  logic                                stat_rd,
  input  logic [cl_fifo_pkg::STAT_ADDR_W-1:0] stat_addr,
  input  logic [cl_fifo_pkg::STAT_DATA_W-1:0] stat_wdata,
  output logic                                stat_ack,
  output logic [cl_fifo_pkg::STAT_DATA_W-1:0] stat_rdata
);

  localparam int REQ_W = $bits(cl_fifo_pkg::stat_req_u);
  localparam int ACK_W = $bits(cl_fifo_pkg::stat_ack_t);

  logic                   sync_rst_n;
  cl_fifo_pkg::stat_req_u stat_req_in;
  cl_fifo_pkg::stat_req_u stat_req_q;
  cl_fifo_pkg::stat_ack_t stat_ack_d;
  cl_fifo_pkg::stat_ack_t stat_ack_q;

  axis_if #(.DATA_W(DATA_W)) wr_strm ();

  cl_reset_flr reset_flr (
    .clk(clk), .pipe_rst_n(pipe_rst_n), .flr_assert(flr_assert),
    .sync_rst_n(sync_rst_n), .flr_done(flr_done)
  );

  //////////////////////////////////////////////////
  // Write capture into the stream FIFO
  //////////////////////////////////////////////////
  pcis_wr_intercept #(.DATA_W(DATA_W)) wr_intercept (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .awvalid(awvalid), .awid(awid), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wlast(wlast), .wready(wready),
    .bvalid(bvalid), .bid(bid), .bresp(bresp), .bready(bready),
    .strm(wr_strm)
  );

  axis_fifo #(.DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH), .CREDITS(CREDITS)) strm_fifo (
    .clk(clk), .sync_rst_n(sync_rst_n), .strm(wr_strm),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
    .out_credit(out_credit)
  );

  //////////////////////////////////////////////////
  // Statistics request and ack paths
  //////////////////////////////////////////////////
  assign stat_req_in.fields = {stat_wr, stat_rd, stat_addr, stat_wdata};

  lib_pipe #(.WIDTH(REQ_W), .STAGES(STAT_STAGES)) pipe_stat_req (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_bus(stat_req_in.raw), .out_bus(stat_req_q.raw)
  );

  ddr_stat_regs stat_regs (
    .clk(clk), .sync_rst_n(sync_rst_n), .req(stat_req_q), .ack(stat_ack_d)
  );

  lib_pipe #(.WIDTH(ACK_W), .STAGES(STAT_STAGES)) pipe_stat_ack (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_bus(stat_ack_d), .out_bus(stat_ack_q)
  );

  assign stat_ack   = stat_ack_q.ack;
  assign stat_rdata = stat_ack_q.rdata;

endmodule

// File: test/tb_cl_fifo.sv
// Testbench for the shell-side wrapper covering reset/FLR, write bursts into the
// credited stream and the pipelined statistics registers
// Outputs are sampled on the falling edge, inputs change 1 ns after the rising edge

`timescale 1ns/1ps

module tb_cl_fifo;

  localparam int DW           = cl_fifo_pkg::DATA_W_DEF;
  localparam int NUM_BURSTS   = 6;
  localparam int CREDIT_BEATS = 24;
  localparam int NUM_RAND_REQ = 20;
  // Beats and requests the run is planned for set the watchdog limit
  localparam int PLANNED      = NUM_BURSTS * 8 + CREDIT_BEATS + 12 + NUM_RAND_REQ;

  logic clk = 1'b0;
  logic pipe_rst_n, flr_assert, flr_done;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic [cl_fifo_pkg::ID_W-1:0] awid, bid;
  logic [1:0] bresp;
  logic [DW-1:0] wdata, out_data;
  logic out_valid, out_last, out_credit;
  logic stat_wr, stat_rd, stat_ack;
  logic [cl_fifo_pkg::STAT_ADDR_W-1:0] stat_addr;
  logic [cl_fifo_pkg::STAT_DATA_W-1:0] stat_wdata, stat_rdata;

  integer seed = 32'hc049_2d81;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  string test_name = "reset";

  // Reference model state
  logic [DW:0] exp_beats [$];
  int exp_ack_cyc [$];
  logic [cl_fifo_pkg::STAT_DATA_W-1:0] exp_ack_data [$];
  logic [cl_fifo_pkg::STAT_DATA_W-1:0] shadow [cl_fifo_pkg::NUM_STAT_REGS];

  // Credit and beat bookkeeping
  logic auto_credit = 1'b1;
  int mon_credits = 0;
  int test_credits = 0;
  int sent_credits = 0;
  int beats_out = 0;
  int accepted_beats = 0;
  logic burst_busy = 1'b0;

  cl_fifo_top UUT (.*);

  always #4 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("ERROR [%s] %s: expected %0h, actual %0h", test_name, name, expected, actual);
    end
  endtask

  // Statistics register behavior on the shadow copy
  function automatic logic [31:0] stat_reference(input logic wr, input logic rd,
                                                 input logic [7:0] addr,
                                                 input logic [31:0] wdata_in);
    logic [31:0] result;
    result = '0;
    if (addr < 8'(cl_fifo_pkg::NUM_STAT_REGS))
    begin
      if (wr)
        shadow[addr[1:0]] = wdata_in;
      if (rd)
        result = shadow[addr[1:0]];
    end
    return result;
  endfunction

  // Request and ack each cross STAT_STAGES registers and the register block adds one
  function automatic int ack_cycle(input int issued);
    return issued + 2 * cl_fifo_pkg::STAT_STAGES_DEF + 1;
  endfunction

  //////////////////////////////////////////////////
  // Output compare
  //////////////////////////////////////////////////
  always @(negedge clk)
  begin : compare_outputs
    logic [DW:0] beat;
    if (wvalid && wready)
      accepted_beats++;
    if (out_valid)
    begin
      beats_out++;
      if (auto_credit)
        mon_credits++;
      if (exp_beats.size() == 0)
      begin
        errors++;
        $display("Stream beat at cycle %0d with nothing expected", cyc);
      end
      else
      begin
        beat = exp_beats.pop_front();
        check("out_data", beat[DW-1:0], out_data);
        check("out_last", 64'(beat[DW]), 64'(out_last));
      end
    end
    if (stat_ack)
    begin
      if (exp_ack_cyc.size() == 0)
      begin
        errors++;
        $display("Statistics ack at cycle %0d with no request in flight", cyc);
      end
      else
      begin
        check("stat_ack_cycle", 64'(exp_ack_cyc.pop_front()), 64'(cyc));
        check("stat_rdata", 64'(exp_ack_data.pop_front()), 64'(stat_rdata));
      end
    end
    else if (exp_ack_cyc.size() != 0 && exp_ack_cyc[0] <= cyc)
    begin
      errors++;
      $display("Statistics ack missing at cycle %0d", exp_ack_cyc.pop_front());
      void'(exp_ack_data.pop_front());
    end
  end

  // Returns one credit per cycle while any are owed
  initial
  begin
    out_credit = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      out_credit = (mon_credits + test_credits > sent_credits);
      if (out_credit)
        sent_credits++;
    end
  end

  initial
  begin
    repeat (PLANNED * 200 + 2000) @(posedge clk);
    $display("Watchdog expired, the run did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

  task automatic write_burst(input logic [cl_fifo_pkg::ID_W-1:0] id, input int len);
    logic [DW-1:0] d;
    logic          taken;
    awvalid = 1'b1;
    awid    = id;
    taken   = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = awready;
      @(posedge clk);
      #1;
    end
    awvalid = 1'b0;
    for (int i = 0; i < len; i++)
    begin
      d      = {$random(seed), $random(seed)};
      wvalid = 1'b1;
      wdata  = d;
      wlast  = (i == len - 1);
      exp_beats.push_back({wlast, d});
      taken = 1'b0;
      while (!taken)
      begin
        @(negedge clk);
        taken = wready;
        @(posedge clk);
        #1;
      end
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    taken  = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = bvalid;
    end
    check("bid", 64'(id), 64'(bid));
    check("bresp", 64'(cl_fifo_pkg::RESP_OKAY), 64'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic issue_stat(input logic wr, input logic rd, input logic [7:0] addr,
                            input logic [31:0] wd);
    stat_wr    = wr;
    stat_rd    = rd;
    stat_addr  = addr;
    stat_wdata = wd;
    exp_ack_cyc.push_back(ack_cycle(cyc));
    exp_ack_data.push_back(stat_reference(wr, rd, addr, wd));
    @(posedge clk);
    #1;
  endtask

  task automatic stat_idle();
    stat_wr = 1'b0;
    stat_rd = 1'b0;
  endtask

  task automatic drain();
    while (exp_beats.size() != 0 || exp_ack_cyc.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    logic [31:0] rnd;
    int flr_start;
    int base_out;
    int base_acc;
    int owed;
    logic stall;
    pipe_rst_n = 1'b0;
    flr_assert = 1'b0;
    awvalid    = 1'b0;
    awid       = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    wlast      = 1'b0;
    bready     = 1'b0;
    stat_wr    = 1'b0;
    stat_rd    = 1'b0;
    stat_addr  = '0;
    stat_wdata = '0;
    for (int i = 0; i < cl_fifo_pkg::NUM_STAT_REGS; i++)
      shadow[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    pipe_rst_n = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check("flr_done", 0, 64'(flr_done));
    check("stat_ack", 0, 64'(stat_ack));
    check("bvalid", 0, 64'(bvalid));
    check("out_valid", 0, 64'(out_valid));
    check("awready", 1, 64'(awready));
    @(posedge clk);
    #1;

    // Single-cycle FLR request gives one done pulse
    test_name  = "flr";
    flr_start  = cyc;
    flr_assert = 1'b1;
    @(posedge clk);
    #1;
    flr_assert = 1'b0;
    repeat (8)
    begin
      @(negedge clk);
      check("flr_done", 64'(cyc == flr_start + 2), 64'(flr_done));
    end
    @(posedge clk);
    #1;

    test_name = "bursts";
    for (int b = 0; b < NUM_BURSTS; b++)
    begin
      rnd = $random(seed);
      write_burst(rnd[13:8], 1 + int'(rnd[2:0]));
    end
    drain();

    // Hold back credits until the FIFO backs up
    test_name   = "credit_limit";
    auto_credit = 1'b0;
    base_out    = beats_out;
    base_acc    = accepted_beats;
    burst_busy  = 1'b1;
    fork
      begin
        write_burst(6'h2a, CREDIT_BEATS);
        burst_busy = 1'b0;
      end
    join_none
    stall = 1'b0;
    while (!stall)
    begin
      @(negedge clk);
      stall = wvalid && !wready;
    end
    check("accepted", 64'(cl_fifo_pkg::FIFO_DEPTH_DEF + cl_fifo_pkg::CREDITS_DEF),
          64'(accepted_beats - base_acc));
    check("sent_no_credit", 64'(cl_fifo_pkg::CREDITS_DEF), 64'(beats_out - base_out));
    repeat (10) @(negedge clk);
    check("held_beats", 64'(cl_fifo_pkg::CREDITS_DEF), 64'(beats_out - base_out));
    check("wready_full", 0, 64'(wready));
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clk);
      test_credits++;
      repeat (6) @(negedge clk);
      check("released", 64'(cl_fifo_pkg::CREDITS_DEF + i + 1), 64'(beats_out - base_out));
    end
    @(posedge clk);
    #1;
    // Credits spent in this test and not yet returned
    owed        = beats_out - base_out - test_credits;
    auto_credit = 1'b1;
    @(negedge clk);
    test_credits += owed;
    while (burst_busy)
      @(posedge clk);
    drain();

    test_name = "stat_rw";
    for (int a = 0; a < cl_fifo_pkg::NUM_STAT_REGS; a++)
      issue_stat(1'b1, 1'b0, 8'(a), $random(seed));
    for (int a = 0; a < cl_fifo_pkg::NUM_STAT_REGS; a++)
      issue_stat(1'b0, 1'b1, 8'(a), '0);
    stat_idle();
    drain();

    test_name = "stat_unmapped";
    issue_stat(1'b0, 1'b1, 8'h04, '0);
    issue_stat(1'b0, 1'b1, 8'h10, '0);
    issue_stat(1'b0, 1'b1, 8'h7f, '0);
    issue_stat(1'b0, 1'b1, 8'hff, '0);
    for (int r = 0; r < NUM_RAND_REQ; r++)
    begin
      rnd = $random(seed);
      // Half the requests land outside the mapped range
      issue_stat(rnd[4], !rnd[4], rnd[3] ? rnd[15:8] : {6'b0, rnd[1:0]}, $random(seed));
    end
    stat_idle();
    drain();

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: all.f
hdl/cl_fifo_pkg.sv
hdl/axis_if.sv
hdl/cl_reset_flr.sv
hdl/lib_pipe.sv
hdl/ddr_stat_regs.sv
hdl/pcis_wr_intercept.sv
hdl/axis_fifo.sv
hdl/cl_fifo_top.sv
test/tb_cl_fifo.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cl_fifo
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
